// ==== bench/id_stage_assertions.sv ====
`default_nettype none

module id_stage_assertions
    import isa_pkg::*;
(
    input wire           clk,
    input wire           rst,
    input wire word_t    inst,
    input wire           br_e,
    input wire           data_ram_en,
    input wire [3:0]     data_ram_wen,
    input wire reg_idx_t rf_waddr
);

    inst_fields_t f;
    logic         is_link;  // jal, jalr, bltzal, bgezal

    assign f = inst;
    assign is_link = (f.opcode == OP_JAL)
                   || (f.opcode == OP_REGIMM && (f.rt == RT_BLTZAL || f.rt == RT_BGEZAL))
                   || (inst != '0 && f.opcode == OP_SPECIAL && f.funct == FN_JALR);

    // empty slot never redirects fetch
    no_branch_on_bubble: assert property (@(posedge clk) disable iff (rst)
        inst == '0 |-> !br_e)
        else $error("branch taken while the decode slot is empty");

    wen_needs_en: assert property (@(posedge clk) disable iff (rst)
        data_ram_wen != '0 |-> data_ram_en)
        else $error("data ram write strobe without ram enable");

    link_to_r31: assert property (@(posedge clk) disable iff (rst)
        is_link |-> rf_waddr == LINK_REG)
        else $error("linking branch does not write the link register");

endmodule

bind id_stage id_stage_assertions u_assertions (
    .clk          (clk),
    .rst          (rst),
    .inst         (inst),
    .br_e         (br_e),
    .data_ram_en  (data_ram_en),
    .data_ram_wen (data_ram_wen),
    .rf_waddr     (rf_waddr)
);

`default_nettype wire

// ==== bench/id_stim.txt ====
// tn sc(stall_if,stall_id,ce) pc inst ex(we,addr) exd mem memd wb wbd ram_read
// then expected: id_pc rf(we,addr) alu_op mem_op rdata1 rdata2 br_e br_addr stallreq
01 1 00400000 00221821 0 0 0 0 0 0 0 00400000 23 800 00 0 0 0 0 0
02 1 00400004 00A62022 0 0 0 0 0 0 0 00400004 24 400 00 0 0 0 0 0
03 1 00400008 0022382A 0 0 0 0 0 0 0 00400008 27 200 00 0 0 0 0 0
04 1 0040000C 000240C3 0 0 0 0 0 0 0 0040000C 28 002 00 0 0 0 0 0
05 1 00400010 342900FF 0 0 0 0 0 0 0 00400010 29 020 00 0 0 0 0 0
06 1 00400014 3C0A1234 0 0 0 0 0 0 0 00400014 2a 001 00 0 0 0 0 0
07 1 00400018 8C2B0004 0 0 0 0 0 0 0 00400018 2b 800 08 0 0 0 0 0
08 1 0040001C 904C0000 0 0 0 0 0 0 0 0040001C 2c 800 40 0 0 0 0 0
09 1 00400020 A4230002 0 0 0 0 0 0 0 00400020 00 800 02 0 0 0 0 0
0a 1 00400024 A0230000 0 0 0 0 0 0 0 00400024 00 800 04 0 0 0 0 0
0b 1 00400028 00221821 21 11111111 21 22222222 21 33333333 0 00400028 23 800 00 11111111 0 0 0 0
0c 1 0040002C 00221821 0 0 21 22222222 21 33333333 0 0040002C 23 800 00 22222222 0 0 0 0
0d 1 00400030 00221821 0 0 0 0 21 33333333 0 00400030 23 800 00 33333333 0 0 0 0
0e 1 00400034 00221821 0 0 0 0 22 44444444 0 00400034 23 800 00 33333333 44444444 0 0 0
0f 1 00400038 00221821 0 0 0 0 0 0 0 00400038 23 800 00 33333333 44444444 0 0 0
10 1 0040003C 00221821 21 5 0 0 0 0 1 0040003C 23 800 00 5 44444444 0 0 1
11 1 00400040 00221821 22 6 0 0 0 0 1 00400040 23 800 00 33333333 6 0 0 1
12 1 00400044 00221821 23 7 0 0 0 0 1 00400044 23 800 00 33333333 44444444 0 0 0
13 1 00400048 00221821 21 5 0 0 0 0 0 00400048 23 800 00 5 44444444 0 0 0
14 1 0040004C 10220004 21 9 22 9 0 0 0 0040004C 00 000 00 9 9 1 00400060 0
15 1 00400050 1422FFFE 21 9 22 9 0 0 0 00400050 00 000 00 9 9 0 0040004C 0
16 1 00400054 04210008 21 0 0 0 0 0 0 00400054 00 000 00 0 0 1 00400078 0
17 1 00400058 1C200001 21 80000000 0 0 0 0 0 00400058 00 000 00 80000000 0 0 00400060 0
18 1 0040005C 18200001 21 0 0 0 0 0 0 0040005C 00 000 00 0 0 1 00400064 0
19 1 00400060 04300003 21 FFFFFFF0 0 0 0 0 0 00400060 3f 800 00 FFFFFFF0 0 1 00400070 0
1a 1 00400064 04510000 0 0 0 0 0 0 0 00400064 3f 800 00 44444444 0 1 00400068 0
1b 1 00400068 04200002 21 1 0 0 0 0 0 00400068 00 000 00 1 0 0 00400074 0
1c 1 0040006C 08100040 0 0 0 0 0 0 0 0040006C 00 000 00 0 0 1 00400100 0
1d 1 00400070 0C000123 0 0 0 0 0 0 0 00400070 3f 800 00 0 0 1 0000048C 0
1e 1 00400074 00200008 21 00401000 0 0 0 0 0 00400074 00 000 00 00401000 0 1 00401000 0
1f 1 00400078 00221821 0 0 0 0 0 0 0 00400078 23 800 00 33333333 44444444 0 0 0
20 3 0040007C 00221821 0 0 0 0 0 0 0 00000000 00 000 00 0 0 0 0 0
21 1 00400080 00A62022 0 0 0 0 0 0 0 00400080 24 400 00 0 0 0 0 0
22 7 00400084 00A62022 0 0 0 0 0 0 0 00400080 24 400 00 0 0 0 0 0
23 7 00400088 342900FF 0 0 0 0 0 0 0 00400080 24 400 00 0 0 0 0 0
24 1 0040008C 342900FF 0 0 0 0 0 0 0 0040008C 29 020 00 33333333 0 0 0 0

// ==== bench/tb_id_stage.sv ====
`default_nettype none

module tb_id_stage
    import isa_pkg::*;
    import pipe_pkg::*;
();

    localparam int NV       = 36;  // vectors in the stim file
    localparam int NF       = 20;  // fields per vector
    localparam int PERIOD   = 40;
    localparam int RST_CYC  = 5;
    localparam int TIMEOUT  = (2 * NV + RST_CYC + 20) * PERIOD;  // two cycles per vector

    logic clk;
    logic rst;
    logic stall_id;
    logic stall_if;
    logic if_ce;
    word_t if_pc;
    word_t inst_sram_rdata;
    logic ex_ram_read;
    logic ex_rf_we;
    reg_idx_t ex_rf_waddr;
    word_t ex_rf_wdata;
    logic mem_rf_we;
    reg_idx_t mem_rf_waddr;
    word_t mem_rf_wdata;
    logic wb_rf_we;
    reg_idx_t wb_rf_waddr;
    word_t wb_rf_wdata;

    word_t id_pc;
    alu_op_t alu_op;
    src1_sel_t src1_sel;
    src2_sel_t src2_sel;
    mem_op_t mem_op;
    logic data_ram_en;
    logic [3:0] data_ram_wen;
    logic rf_we;
    reg_idx_t rf_waddr;
    logic sel_rf_res;
    word_t rdata1;
    word_t rdata2;
    logic br_e;
    word_t br_addr;
    logic stallreq_for_load;

    logic [31:0] stim [NV*NF];
    int errors;
    int vec_errors;
    int failed_tests;

    // model of the decode slot across stalls
    logic  slot_full;
    logic  held_valid;
    word_t held_word;

    id_stage dut (.*);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT);
        $display("watchdog expired before all vectors were checked");
        $display("ERRORS FOUND");
        $finish;
    end

    task automatic drive_vector(input int v);
        int b;
        b = v * NF;
        stall_if        <= stim[b+1][2];
        stall_id        <= stim[b+1][1];
        if_ce           <= stim[b+1][0];
        if_pc           <= stim[b+2];
        inst_sram_rdata <= stim[b+3];
        ex_rf_we        <= stim[b+4][5];
        ex_rf_waddr     <= stim[b+4][4:0];
        ex_rf_wdata     <= stim[b+5];
        mem_rf_we       <= stim[b+6][5];
        mem_rf_waddr    <= stim[b+6][4:0];
        mem_rf_wdata    <= stim[b+7];
        wb_rf_we        <= stim[b+8][5];
        wb_rf_waddr     <= stim[b+8][4:0];
        wb_rf_wdata     <= stim[b+9];
        ex_ram_read     <= stim[b+10][0];
    endtask

    task automatic compare_field(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Fail %s expected %h got %h", name, expected, actual);
            vec_errors++;
        end
    endtask

    // {src1_sel, src2_sel} for the word in decode
    function automatic logic [6:0] expected_sources(input word_t dec_word,
                                                    input alu_op_t exp_alu,
                                                    input mem_op_t exp_mem);
        inst_fields_t fw;
        logic         linking;
        fw      = dec_word;
        linking = (fw.opcode == OP_JAL) || (fw.opcode == OP_REGIMM)
                || (fw.opcode == OP_SPECIAL && fw.funct == FN_JALR);
        if (exp_alu == '0) begin
            return '0;  // no ALU work
        end
        if (exp_mem != '0) begin
            return {SRC1_RS, SRC2_SIMM};  // base plus offset
        end
        if (linking) begin
            return {SRC1_PC, SRC2_EIGHT};
        end
        if (fw.opcode == OP_SPECIAL) begin
            if (fw.funct inside {FN_SLL, FN_SRL, FN_SRA}) begin
                return {SRC1_SA, SRC2_RT};
            end
            return {SRC1_RS, SRC2_RT};
        end
        if (exp_alu == ALU_LUI) begin
            return {3'b000, SRC2_SIMM};  // immediate only
        end
        if (exp_alu inside {ALU_AND, ALU_OR, ALU_XOR}) begin
            return {SRC1_RS, SRC2_ZIMM};  // logical immediates zero-extend
        end
        return {SRC1_RS, SRC2_SIMM};
    endfunction

    // one strobe per byte stored, from lane 0
    function automatic logic [3:0] store_strobes(input mem_op_t exp_mem);
        case (exp_mem)
            MEM_SW:  return 4'b1111;
            MEM_SH:  return 4'b0011;
            MEM_SB:  return 4'b0001;
            default: return 4'b0000;
        endcase
    endfunction

    task automatic check_vector(input int v);
        int         b;
        mem_op_t    exp_mem;
        logic [6:0] srcs;
        word_t      dec_word;
        b = v * NF;
        vec_errors = 0;
        exp_mem = stim[b+14][7:0];

        if (!stim[b+1][1]) begin
            slot_full  = stim[b+1][0];
            held_valid = 1'b0;
        end else if (!stim[b+1][2]) begin
            slot_full  = 1'b0;  // bubble
            held_valid = 1'b0;
        end else if (!held_valid) begin
            held_word  = stim[b+3];
            held_valid = 1'b1;
        end
        dec_word = !slot_full ? '0 : held_valid ? held_word : stim[b+3];
        srcs = expected_sources(dec_word, stim[b+13][11:0], exp_mem);

        compare_field("id_pc", stim[b+11], id_pc);
        compare_field("rf_we", 32'(stim[b+12][5]), 32'(rf_we));
        compare_field("rf_waddr", 32'(stim[b+12][4:0]), 32'(rf_waddr));
        compare_field("alu_op", 32'(stim[b+13][11:0]), 32'(alu_op));
        compare_field("mem_op", 32'(exp_mem), 32'(mem_op));
        compare_field("src1_sel", 32'(srcs[6:4]), 32'(src1_sel));
        compare_field("src2_sel", 32'(srcs[3:0]), 32'(src2_sel));
        compare_field("data_ram_en", 32'(exp_mem != '0), 32'(data_ram_en));
        compare_field("data_ram_wen", 32'(store_strobes(exp_mem)), 32'(data_ram_wen));
        compare_field("sel_rf_res", 32'(exp_mem[7:3] != '0), 32'(sel_rf_res));
        compare_field("rdata1", stim[b+15], rdata1);
        compare_field("rdata2", stim[b+16], rdata2);
        compare_field("br_e", 32'(stim[b+17][0]), 32'(br_e));
        compare_field("br_addr", stim[b+18], br_addr);
        compare_field("stallreq_for_load", 32'(stim[b+19][0]), 32'(stallreq_for_load));
        if (vec_errors == 0) begin
            $display("test %0d passed", stim[b]);
        end else begin
            $display("test %0d failed with %0d mismatches", stim[b], vec_errors);
            failed_tests++;
            errors += vec_errors;
        end
    endtask

    initial begin
        errors          = 0;
        failed_tests    = 0;
        slot_full       = 1'b0;
        held_valid      = 1'b0;
        held_word       = '0;
        rst             = 1'b1;
        stall_id        = 1'b0;
        stall_if        = 1'b0;
        if_ce           = 1'b0;
        if_pc           = '0;
        inst_sram_rdata = '0;
        ex_ram_read     = 1'b0;
        ex_rf_we        = 1'b0;
        ex_rf_waddr     = '0;
        ex_rf_wdata     = '0;
        mem_rf_we       = 1'b0;
        mem_rf_waddr    = '0;
        mem_rf_wdata    = '0;
        wb_rf_we        = 1'b0;
        wb_rf_waddr     = '0;
        wb_rf_wdata     = '0;
        $readmemh("bench/id_stim.txt", stim);

        repeat (RST_CYC) @(posedge clk);
        rst <= 1'b0;

        for (int v = 0; v < NV; v++) begin
            @(posedge clk);
            drive_vector(v);
            @(posedge clk);   // input register captures the vector
            @(negedge clk);
            check_vector(v);
        end

        $display("%0d tests run, %0d failed, %0d mismatches", NV, failed_tests, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/branch_unit.sv ====
`default_nettype none

module branch_unit
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  wire word_t    inst,
    input  wire word_t    id_pc,
    input  wire br_kind_t br_kind,
    input  wire word_t    rdata1,
    input  wire word_t    rdata2,
    output logic          br_e,
    output word_t         br_addr
);

    word_t pc_plus_4;
    word_t br_offset;  // sign-extended, word aligned
    logic  rs_zero;

    assign pc_plus_4 = id_pc + 32'd4;
    assign br_offset = {{(32 - IMM_W - 2){inst[IMM_W-1]}}, inst[IMM_W-1:0], 2'b00};
    assign rs_zero   = (rdata1 == '0);

    always_comb begin
        case (br_kind)
            BR_BEQ:  br_e = (rdata1 == rdata2);
            BR_BNE:  br_e = (rdata1 != rdata2);
            BR_BGEZ: br_e = !rdata1[31];
            BR_BGTZ: br_e = !rdata1[31] && !rs_zero;
            BR_BLEZ: br_e = rdata1[31] || rs_zero;
            BR_BLTZ: br_e = rdata1[31];
            BR_JIDX, BR_JREG: br_e = 1'b1;
            default: br_e = 1'b0;
        endcase
    end

    always_comb begin
        case (br_kind)
            BR_NONE: br_addr = '0;
            BR_JIDX: br_addr = {id_pc[31:28], inst[INDEX_W-1:0], 2'b00};  // same 256M region
            BR_JREG: br_addr = rdata1;
            default: br_addr = pc_plus_4 + br_offset;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/id_input_reg.sv ====
`default_nettype none

module id_input_reg
    import isa_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire        stall_id,
    input  wire        stall_if,
    input  wire        if_ce,
    input  wire word_t if_pc,
    input  wire word_t inst_sram_rdata,
    output word_t      inst,
    output word_t      id_pc
);

    logic  ce;        // slot holds a real fetch
    logic  buf_flag;  // buf_inst valid
    word_t buf_inst;

    always_ff @(posedge clk) begin
        if (rst) begin
            ce       <= 1'b0;
            id_pc    <= '0;
            buf_flag <= 1'b0;
        end else if (!stall_id) begin
            ce       <= if_ce;
            id_pc    <= if_pc;
            buf_flag <= 1'b0;
        end else if (!stall_if) begin
            // only ID held, so push a bubble forward
            ce       <= 1'b0;
            id_pc    <= '0;
            buf_flag <= 1'b0;
        end else if (!buf_flag) begin
            buf_flag <= 1'b1;
        end
    end

    // sram data is only valid for one cycle, keep it across a double stall
    always_ff @(posedge clk) begin
        if (stall_id && stall_if && !buf_flag) begin
            buf_inst <= inst_sram_rdata;
        end
    end

    assign inst = !ce     ? '0
                : buf_flag ? buf_inst
                :            inst_sram_rdata;

endmodule

`default_nettype wire

// ==== hw/id_stage.sv ====
`default_nettype none

module id_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  wire           clk,
    input  wire           rst,
    input  wire           stall_id,  // stall bus bit 1
    input  wire           stall_if,  // stall bus bit 2
    input  wire           if_ce,
    input  wire word_t    if_pc,
    input  wire word_t    inst_sram_rdata,
    input  wire           ex_ram_read,
    input  wire           ex_rf_we,
    input  wire reg_idx_t ex_rf_waddr,
    input  wire word_t    ex_rf_wdata,
    input  wire           mem_rf_we,
    input  wire reg_idx_t mem_rf_waddr,
    input  wire word_t    mem_rf_wdata,
    input  wire           wb_rf_we,
    input  wire reg_idx_t wb_rf_waddr,
    input  wire word_t    wb_rf_wdata,
    output word_t         id_pc,
    output alu_op_t       alu_op,
    output src1_sel_t     src1_sel,
    output src2_sel_t     src2_sel,
    output mem_op_t       mem_op,
    output logic          data_ram_en,
    output logic [3:0]    data_ram_wen,
    output logic          rf_we,
    output reg_idx_t      rf_waddr,
    output logic          sel_rf_res,
    output word_t         rdata1,
    output word_t         rdata2,
    output logic          br_e,
    output word_t         br_addr,
    output logic          stallreq_for_load
);

    word_t inst;
    ctrl_t ctrl;
    fwd_t  ex_fwd;
    fwd_t  mem_fwd;
    fwd_t  wb_fwd;

    rf_read_if rf_rd ();

    assign ex_fwd  = '{we: ex_rf_we,  waddr: ex_rf_waddr,  wdata: ex_rf_wdata};
    assign mem_fwd = '{we: mem_rf_we, waddr: mem_rf_waddr, wdata: mem_rf_wdata};
    assign wb_fwd  = '{we: wb_rf_we,  waddr: wb_rf_waddr,  wdata: wb_rf_wdata};

    id_input_reg u_input_reg (
        .clk             (clk),
        .rst             (rst),
        .stall_id        (stall_id),
        .stall_if        (stall_if),
        .if_ce           (if_ce),
        .if_pc           (if_pc),
        .inst_sram_rdata (inst_sram_rdata),
        .inst            (inst),
        .id_pc           (id_pc)
    );

    inst_decoder u_decoder (
        .inst (inst),
        .ctrl (ctrl)
    );

    regfile u_regfile (
        .clk (clk),
        .rst (rst),
        .rd  (rf_rd),
        .wb  (wb_fwd)
    );

    operand_fetch u_operand_fetch (
        .inst              (inst),
        .ex                (ex_fwd),
        .mem               (mem_fwd),
        .wb                (wb_fwd),
        .ex_ram_read       (ex_ram_read),
        .rf                (rf_rd),
        .rdata1            (rdata1),
        .rdata2            (rdata2),
        .stallreq_for_load (stallreq_for_load)
    );

    branch_unit u_branch (
        .inst    (inst),
        .id_pc   (id_pc),
        .br_kind (ctrl.br_kind),
        .rdata1  (rdata1),
        .rdata2  (rdata2),
        .br_e    (br_e),
        .br_addr (br_addr)
    );

    // ID-to-EX control fields
    assign alu_op       = ctrl.alu_op;
    assign src1_sel     = ctrl.src1_sel;
    assign src2_sel     = ctrl.src2_sel;
    assign mem_op       = ctrl.mem_op;
    assign data_ram_en  = ctrl.data_ram_en;
    assign data_ram_wen = ctrl.data_ram_wen;
    assign rf_we        = ctrl.rf_we;
    assign rf_waddr     = ctrl.rf_waddr;
    assign sel_rf_res   = ctrl.sel_rf_res;

endmodule

`default_nettype wire

// ==== hw/inst_decoder.sv ====
`default_nettype none

module inst_decoder
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  wire word_t inst,
    output ctrl_t      ctrl
);

    inst_fields_t f;

    assign f = inst;

    always_comb begin : decode
        logic link;     // pc + 8 into r31
        logic imm_alu;  // i-type alu op, result to rt
        logic zext;     // logical immediates are zero-extended

        ctrl    = '0;
        link    = 1'b0;
        imm_alu = 1'b0;
        zext    = 1'b0;

        case (f.opcode)
            OP_SPECIAL: begin
                ctrl.src1_sel = SRC1_RS;
                ctrl.src2_sel = SRC2_RT;
                ctrl.rf_we    = 1'b1;
                ctrl.rf_waddr = f.rd;
                case (f.funct)
                    FN_ADD, FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUB, FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_SLT:          ctrl.alu_op = ALU_SLT;
                    FN_SLTU:         ctrl.alu_op = ALU_SLTU;
                    FN_AND:          ctrl.alu_op = ALU_AND;
                    FN_OR:           ctrl.alu_op = ALU_OR;
                    FN_XOR:          ctrl.alu_op = ALU_XOR;
                    FN_NOR:          ctrl.alu_op = ALU_NOR;
                    FN_SLLV:         ctrl.alu_op = ALU_SLL;
                    FN_SRLV:         ctrl.alu_op = ALU_SRL;
                    FN_SRAV:         ctrl.alu_op = ALU_SRA;
                    FN_SLL, FN_SRL, FN_SRA: begin
                        // shift amount from the sa field
                        ctrl.src1_sel = SRC1_SA;
                        ctrl.alu_op   = (f.funct == FN_SLL) ? ALU_SLL
                                      : (f.funct == FN_SRL) ? ALU_SRL : ALU_SRA;
                    end
                    FN_JR: begin
                        ctrl         = '0;
                        ctrl.br_kind = BR_JREG;
                    end
                    FN_JALR: begin
                        link         = 1'b1;
                        ctrl.br_kind = BR_JREG;
                    end
                    default: ctrl = '0;
                endcase
            end
            OP_REGIMM: begin
                case (f.rt)
                    RT_BLTZ: ctrl.br_kind = BR_BLTZ;
                    RT_BGEZ: ctrl.br_kind = BR_BGEZ;
                    RT_BLTZAL: begin
                        ctrl.br_kind = BR_BLTZ;
                        link         = 1'b1;
                    end
                    RT_BGEZAL: begin
                        ctrl.br_kind = BR_BGEZ;
                        link         = 1'b1;
                    end
                    default: ;
                endcase
            end
            OP_J: ctrl.br_kind = BR_JIDX;
            OP_JAL: begin
                ctrl.br_kind = BR_JIDX;
                link         = 1'b1;
            end
            OP_BEQ:  ctrl.br_kind = BR_BEQ;
            OP_BNE:  ctrl.br_kind = BR_BNE;
            OP_BLEZ: ctrl.br_kind = BR_BLEZ;
            OP_BGTZ: ctrl.br_kind = BR_BGTZ;
            OP_ADDI, OP_ADDIU: begin
                imm_alu     = 1'b1;
                ctrl.alu_op = ALU_ADD;
            end
            OP_SLTI, OP_SLTIU: begin
                imm_alu     = 1'b1;
                ctrl.alu_op = (f.opcode == OP_SLTI) ? ALU_SLT : ALU_SLTU;
            end
            OP_ANDI, OP_ORI, OP_XORI: begin
                imm_alu     = 1'b1;
                zext        = 1'b1;
                ctrl.alu_op = (f.opcode == OP_ANDI) ? ALU_AND
                            : (f.opcode == OP_ORI)  ? ALU_OR : ALU_XOR;
            end
            OP_LUI: begin
                imm_alu     = 1'b1;
                ctrl.alu_op = ALU_LUI;
            end
            OP_LB:  ctrl.mem_op = MEM_LB;
            OP_LBU: ctrl.mem_op = MEM_LBU;
            OP_LH:  ctrl.mem_op = MEM_LH;
            OP_LHU: ctrl.mem_op = MEM_LHU;
            OP_LW:  ctrl.mem_op = MEM_LW;
            OP_SB:  ctrl.mem_op = MEM_SB;
            OP_SH:  ctrl.mem_op = MEM_SH;
            OP_SW:  ctrl.mem_op = MEM_SW;
            default: ;
        endcase

        if (imm_alu) begin
            ctrl.src1_sel = (ctrl.alu_op == ALU_LUI) ? '0 : SRC1_RS;  // lui has no rs
            ctrl.src2_sel = zext ? SRC2_ZIMM : SRC2_SIMM;
            ctrl.rf_we    = 1'b1;
            ctrl.rf_waddr = f.rt;
        end

        if (ctrl.mem_op != '0) begin
            ctrl.alu_op      = ALU_ADD;  // address is rs + offset
            ctrl.src1_sel    = SRC1_RS;
            ctrl.src2_sel    = SRC2_SIMM;
            ctrl.data_ram_en = 1'b1;
            if ((ctrl.mem_op & MEM_STORES) != '0) begin
                // lane pattern before the address shift in EX
                ctrl.data_ram_wen = (ctrl.mem_op == MEM_SW) ? 4'b1111
                                  : (ctrl.mem_op == MEM_SH) ? 4'b0011 : 4'b0001;
            end else begin
                ctrl.rf_we      = 1'b1;
                ctrl.rf_waddr   = f.rt;
                ctrl.sel_rf_res = 1'b1;
            end
        end

        if (link) begin
            ctrl.alu_op   = ALU_ADD;
            ctrl.src1_sel = SRC1_PC;
            ctrl.src2_sel = SRC2_EIGHT;
            ctrl.rf_we    = 1'b1;
            ctrl.rf_waddr = LINK_REG;
        end

        // all-zero word is an empty slot, not sll r0
        if (inst == '0) begin
            ctrl = '0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // r-type view of the word; i-type imm is {rd, sa, funct}
    typedef struct packed {
        logic [5:0] opcode;
        reg_idx_t   rs;
        reg_idx_t   rt;
        reg_idx_t   rd;
        logic [4:0] sa;
        logic [5:0] funct;
    } inst_fields_t;

    localparam int IMM_W   = 16;  // offset / immediate
    localparam int INDEX_W = 26;  // j, jal target index

    // opcodes
    localparam logic [5:0] OP_SPECIAL = 6'b00_0000;
    localparam logic [5:0] OP_REGIMM  = 6'b00_0001;
    localparam logic [5:0] OP_J       = 6'b00_0010;
    localparam logic [5:0] OP_JAL     = 6'b00_0011;
    localparam logic [5:0] OP_BEQ     = 6'b00_0100;
    localparam logic [5:0] OP_BNE     = 6'b00_0101;
    localparam logic [5:0] OP_BLEZ    = 6'b00_0110;
    localparam logic [5:0] OP_BGTZ    = 6'b00_0111;
    localparam logic [5:0] OP_ADDI    = 6'b00_1000;
    localparam logic [5:0] OP_ADDIU   = 6'b00_1001;
    localparam logic [5:0] OP_SLTI    = 6'b00_1010;
    localparam logic [5:0] OP_SLTIU   = 6'b00_1011;
    localparam logic [5:0] OP_ANDI    = 6'b00_1100;
    localparam logic [5:0] OP_ORI     = 6'b00_1101;
    localparam logic [5:0] OP_XORI    = 6'b00_1110;
    localparam logic [5:0] OP_LUI     = 6'b00_1111;
    localparam logic [5:0] OP_LB      = 6'b10_0000;
    localparam logic [5:0] OP_LH      = 6'b10_0001;
    localparam logic [5:0] OP_LW      = 6'b10_0011;
    localparam logic [5:0] OP_LBU     = 6'b10_0100;
    localparam logic [5:0] OP_LHU     = 6'b10_0101;
    localparam logic [5:0] OP_SB      = 6'b10_1000;
    localparam logic [5:0] OP_SH      = 6'b10_1001;
    localparam logic [5:0] OP_SW      = 6'b10_1011;

    // funct codes under OP_SPECIAL
    localparam logic [5:0] FN_SLL  = 6'b00_0000;
    localparam logic [5:0] FN_SRL  = 6'b00_0010;
    localparam logic [5:0] FN_SRA  = 6'b00_0011;
    localparam logic [5:0] FN_SLLV = 6'b00_0100;
    localparam logic [5:0] FN_SRLV = 6'b00_0110;
    localparam logic [5:0] FN_SRAV = 6'b00_0111;
    localparam logic [5:0] FN_JR   = 6'b00_1000;
    localparam logic [5:0] FN_JALR = 6'b00_1001;
    localparam logic [5:0] FN_ADD  = 6'b10_0000;
    localparam logic [5:0] FN_ADDU = 6'b10_0001;
    localparam logic [5:0] FN_SUB  = 6'b10_0010;
    localparam logic [5:0] FN_SUBU = 6'b10_0011;
    localparam logic [5:0] FN_AND  = 6'b10_0100;
    localparam logic [5:0] FN_OR   = 6'b10_0101;
    localparam logic [5:0] FN_XOR  = 6'b10_0110;
    localparam logic [5:0] FN_NOR  = 6'b10_0111;
    localparam logic [5:0] FN_SLT  = 6'b10_1010;
    localparam logic [5:0] FN_SLTU = 6'b10_1011;

    // rt field under OP_REGIMM
    localparam logic [4:0] RT_BLTZ   = 5'b0_0000;
    localparam logic [4:0] RT_BGEZ   = 5'b0_0001;
    localparam logic [4:0] RT_BLTZAL = 5'b1_0000;
    localparam logic [4:0] RT_BGEZAL = 5'b1_0001;

    localparam reg_idx_t LINK_REG    = 5'd31;
    localparam word_t    LINK_OFFSET = 32'd8;  // return address is pc + 8

endpackage

`default_nettype wire

// ==== hw/operand_fetch.sv ====
`default_nettype none

module operand_fetch
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  wire word_t inst,
    input  wire fwd_t  ex,
    input  wire fwd_t  mem,
    input  wire fwd_t  wb,
    input  wire        ex_ram_read,
    rf_read_if.client  rf,
    output word_t      rdata1,
    output word_t      rdata2,
    output logic       stallreq_for_load
);

    inst_fields_t f;

    // youngest writer wins
    function automatic word_t pick(reg_idx_t addr, word_t rf_val);
        if (ex.we && ex.waddr == addr) begin
            return ex.wdata;
        end else if (mem.we && mem.waddr == addr) begin
            return mem.wdata;
        end else if (wb.we && wb.waddr == addr) begin
            return wb.wdata;  // same-cycle write not yet in the array
        end
        return rf_val;
    endfunction

    assign f = inst;

    assign rf.raddr1 = f.rs;
    assign rf.raddr2 = f.rt;

    // pick reads the forwarding buses directly
    always_comb begin
        rdata1 = pick(f.rs, rf.rdata1);
        rdata2 = pick(f.rt, rf.rdata2);
    end

    // load data only exists after MEM, so EX can't forward it
    assign stallreq_for_load = ex_ram_read && ex.we
                             && (ex.waddr == f.rs || ex.waddr == f.rt);

endmodule

`default_nettype wire

// ==== hw/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

    import isa_pkg::*;

    // alu op, one-hot, msb first: add sub slt sltu and nor or xor sll srl sra lui
    typedef logic [11:0] alu_op_t;
    localparam alu_op_t ALU_ADD  = 12'b1000_0000_0000;
    localparam alu_op_t ALU_SUB  = 12'b0100_0000_0000;
    localparam alu_op_t ALU_SLT  = 12'b0010_0000_0000;
    localparam alu_op_t ALU_SLTU = 12'b0001_0000_0000;
    localparam alu_op_t ALU_AND  = 12'b0000_1000_0000;
    localparam alu_op_t ALU_NOR  = 12'b0000_0100_0000;
    localparam alu_op_t ALU_OR   = 12'b0000_0010_0000;
    localparam alu_op_t ALU_XOR  = 12'b0000_0001_0000;
    localparam alu_op_t ALU_SLL  = 12'b0000_0000_1000;
    localparam alu_op_t ALU_SRL  = 12'b0000_0000_0100;
    localparam alu_op_t ALU_SRA  = 12'b0000_0000_0010;
    localparam alu_op_t ALU_LUI  = 12'b0000_0000_0001;

    typedef logic [2:0] src1_sel_t;
    localparam src1_sel_t SRC1_RS = 3'b001;
    localparam src1_sel_t SRC1_PC = 3'b010;
    localparam src1_sel_t SRC1_SA = 3'b100;  // zero-extended shamt

    typedef logic [3:0] src2_sel_t;
    localparam src2_sel_t SRC2_RT    = 4'b0001;
    localparam src2_sel_t SRC2_SIMM  = 4'b0010;
    localparam src2_sel_t SRC2_EIGHT = 4'b0100;
    localparam src2_sel_t SRC2_ZIMM  = 4'b1000;

    // msb first: lb lbu lh lhu lw sb sh sw
    typedef logic [7:0] mem_op_t;
    localparam mem_op_t MEM_LB  = 8'b1000_0000;
    localparam mem_op_t MEM_LBU = 8'b0100_0000;
    localparam mem_op_t MEM_LH  = 8'b0010_0000;
    localparam mem_op_t MEM_LHU = 8'b0001_0000;
    localparam mem_op_t MEM_LW  = 8'b0000_1000;
    localparam mem_op_t MEM_SB  = 8'b0000_0100;
    localparam mem_op_t MEM_SH  = 8'b0000_0010;
    localparam mem_op_t MEM_SW  = 8'b0000_0001;
    localparam mem_op_t MEM_STORES = MEM_SB | MEM_SH | MEM_SW;

    // linking forms share the kind of their plain form
    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BGEZ, BR_BGTZ,
        BR_BLEZ, BR_BLTZ, BR_JIDX, BR_JREG
    } br_kind_t;

    // write-back view of a later stage
    typedef struct packed {
        logic     we;
        reg_idx_t waddr;
        word_t    wdata;
    } fwd_t;

    typedef struct packed {
        alu_op_t   alu_op;
        src1_sel_t src1_sel;
        src2_sel_t src2_sel;
        mem_op_t   mem_op;
        logic      data_ram_en;
        logic [3:0] data_ram_wen;
        logic      rf_we;
        reg_idx_t  rf_waddr;
        logic      sel_rf_res;  // 1: result from load data
        br_kind_t  br_kind;
    } ctrl_t;

endpackage

`default_nettype wire

// ==== hw/regfile.sv ====
`default_nettype none

module regfile
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    rf_read_if.server  rd,
    input  wire fwd_t  wb
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.we) begin
            regs[wb.waddr] <= wb.wdata;
        end
    end

    // r0 reads as zero whatever was written there
    assign rd.rdata1 = (rd.raddr1 == '0) ? '0 : regs[rd.raddr1];
    assign rd.rdata2 = (rd.raddr2 == '0) ? '0 : regs[rd.raddr2];

endmodule

`default_nettype wire

// ==== hw/rf_read_if.sv ====
`default_nettype none

// two combinational read ports of the register file
interface rf_read_if
    import isa_pkg::*;
();
    reg_idx_t raddr1;
    reg_idx_t raddr2;
    word_t    rdata1;
    word_t    rdata2;

    modport client (output raddr1, output raddr2, input rdata1, input rdata2);
    modport server (input raddr1, input raddr2, output rdata1, output rdata2);

endinterface

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the ID stage testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module tb_id_stage \
    -f verilog.f

./obj_dir/Vtb_id_stage | tee sim.log

if grep -q "NO ERRORS" sim.log; then
    exit 0
fi
exit 1

// ==== verilog.f ====
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/rf_read_if.sv
hw/id_input_reg.sv
hw/inst_decoder.sv
hw/regfile.sv
hw/operand_fetch.sv
hw/branch_unit.sv
hw/id_stage.sv
bench/id_stage_assertions.sv
bench/tb_id_stage.sv
